/* Bender.yml */
package:
  name: decode_stage

sources:
  - rtl/decode_pkg.sv
  - rtl/imm_gen.sv
  - rtl/control_unit.sv
  - rtl/hazard_unit.sv
  - rtl/fetch_buffer.sv
  - rtl/decode_stage.sv
  - rtl/decode_top.sv
  - target: test
    files:
      - test/decode_tb.sv

/* compile.f */
rtl/decode_pkg.sv
rtl/imm_gen.sv
rtl/control_unit.sv
rtl/hazard_unit.sv
rtl/fetch_buffer.sv
rtl/decode_stage.sv
rtl/decode_top.sv
test/decode_tb.sv

/* rtl/control_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module control_unit (
  input  logic [decode_pkg::xlen-1:0] ins,
  output decode_pkg::ctrl_t           ctrl
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = ins[6:0];
  assign funct3 = ins[14:12];
  assign funct7 = ins[31:25];

  // Shared by register and immediate arithmetic
  function automatic decode_pkg::alu_op_e alu_from_funct3(input logic [2:0] f3,
                                                          input logic alt);
    case (f3)
      3'b000:  return alt ? decode_pkg::alu_sub : decode_pkg::alu_add;
      3'b001:  return decode_pkg::alu_sll;
      3'b010:  return decode_pkg::alu_slt;
      3'b011:  return decode_pkg::alu_sltu;
      3'b100:  return decode_pkg::alu_xor;
      3'b101:  return alt ? decode_pkg::alu_sra : decode_pkg::alu_srl;
      3'b110:  return decode_pkg::alu_or;
      default: return decode_pkg::alu_and;
    endcase
  endfunction

  always_comb begin
    ctrl = '0;
    // funct3 passed on for every format that carries one
    ctrl.mem_size = funct3;
    unique case (opcode)
      decode_pkg::op_lui: begin
        ctrl.alu_op   = decode_pkg::alu_pass_b;
        ctrl.alusrc   = 1'b1;
        ctrl.regwrite = 1'b1;
        ctrl.lui      = 1'b1;
        ctrl.mem_size = 3'b000;
      end
      decode_pkg::op_auipc: begin
        ctrl.alusrc   = 1'b1;
        ctrl.regwrite = 1'b1;
        ctrl.auipc    = 1'b1;
        ctrl.mem_size = 3'b000;
      end
      decode_pkg::op_jal: begin
        ctrl.regwrite = 1'b1;
        ctrl.jal      = 1'b1;
        ctrl.mem_size = 3'b000;
      end
      decode_pkg::op_jalr: begin
        ctrl.alusrc   = 1'b1;
        ctrl.regwrite = 1'b1;
        ctrl.jalr     = 1'b1;
      end
      decode_pkg::op_branch: begin
        ctrl.branch = 1'b1;
        // Equality by subtract, ordering by set-less-than
        case (funct3[2:1])
          2'b10:   ctrl.alu_op = decode_pkg::alu_slt;
          2'b11:   ctrl.alu_op = decode_pkg::alu_sltu;
          default: ctrl.alu_op = decode_pkg::alu_sub;
        endcase
      end
      decode_pkg::op_load: begin
        ctrl.alusrc   = 1'b1;
        ctrl.memread  = 1'b1;
        ctrl.regwrite = 1'b1;
      end
      decode_pkg::op_store: begin
        ctrl.alusrc   = 1'b1;
        ctrl.memwrite = 1'b1;
      end
      decode_pkg::op_imm: begin
        ctrl.alusrc   = 1'b1;
        ctrl.regwrite = 1'b1;
        // Only srai uses the alternate bit, addi has no subtract
        ctrl.alu_op   = alu_from_funct3(funct3, (funct3 == 3'b101) & funct7[5]);
      end
      decode_pkg::op_reg: begin
        ctrl.regwrite = 1'b1;
        ctrl.alu_op   = alu_from_funct3(funct3, funct7[5]);
      end
      default: begin
        ctrl.illegal  = 1'b1;
        ctrl.mem_size = 3'b000;
      end
    endcase
  end

endmodule

`default_nettype wire

/* rtl/decode_pkg.sv */
`default_nettype none

package decode_pkg;

  ////////////////////////////////////////
  // Widths and sizes
  ////////////////////////////////////////

  localparam int xlen        = 32;
  localparam int pc_width    = 16;
  localparam int fetch_depth = 4;

  // RV32I base opcodes
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;

  ////////////////////////////////////////
  // Payloads between blocks
  ////////////////////////////////////////

  // One fetched word with its address
  typedef struct packed {
    logic [pc_width-1:0] pc;
    logic [xlen-1:0]     ins;
  } fetch_t;

  // add must stay at zero so a cleared word reads as a bubble
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_e;

  typedef struct packed {
    alu_op_e    alu_op;
    logic       alusrc;
    logic       memread;
    logic       memwrite;
    logic       regwrite;
    logic       branch;
    logic       jal;
    logic       jalr;
    logic       lui;
    logic       auipc;
    logic [2:0] mem_size;
    logic       illegal;
  } ctrl_t;

  // Word handed to execute
  typedef struct packed {
    logic                valid;
    logic [pc_width-1:0] pc;
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [4:0]          rd;
    logic [xlen-1:0]     imm;
    ctrl_t               ctrl;
  } id_ex_t;

endpackage

`default_nettype wire

/* rtl/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  logic                 bus,
  input  logic                 rst_n,
  input  logic                 ex_hold,
  input  decode_pkg::fetch_t   head,
  input  logic                 head_valid,
  output logic                 pop,
  output decode_pkg::id_ex_t   id_ex
);

  logic [decode_pkg::xlen-1:0] ins;
  logic [4:0]                  rs1;
  logic [4:0]                  rs2;
  logic [4:0]                  rd;
  logic [decode_pkg::xlen-1:0] imm;
  decode_pkg::ctrl_t           ctrl;
  logic                        uses_rs1;
  logic                        uses_rs2;
  logic                        stall;
  logic                        issue;
  decode_pkg::id_ex_t          id_ex_next;

  ////////////////////////////////////////
  // Field split
  ////////////////////////////////////////

  assign ins = head.ins;
  assign rs1 = ins[19:15];
  assign rs2 = ins[24:20];
  assign rd  = ins[11:7];

  imm_gen imm_gen_i (
    .ins (ins),
    .imm (imm)
  );

  control_unit control_unit_i (
    .ins  (ins),
    .ctrl (ctrl)
  );

  // U and J formats and unknown words read no register
  assign uses_rs1 = !(ctrl.lui || ctrl.auipc || ctrl.jal || ctrl.illegal);
  // Register-register ops are the writers without an immediate
  assign uses_rs2 = ctrl.branch || ctrl.memwrite ||
                    (ctrl.regwrite && !ctrl.alusrc && !ctrl.jal);

  hazard_unit hazard_unit_i (
    .rs1           (rs1),
    .rs2           (rs2),
    .uses_rs1      (uses_rs1),
    .uses_rs2      (uses_rs2),
    .id_ex_rd      (id_ex.rd),
    .id_ex_memread (id_ex.ctrl.memread),
    .stall         (stall)
  );

  ////////////////////////////////////////
  // Issue or bubble
  ////////////////////////////////////////

  assign issue = head_valid && !stall;
  assign pop   = issue && !ex_hold;

  always_comb begin
    id_ex_next       = '0;
    id_ex_next.valid = 1'b1;
    id_ex_next.pc    = head.pc;
    id_ex_next.rs1   = rs1;
    id_ex_next.rs2   = rs2;
    id_ex_next.rd    = rd;
    id_ex_next.imm   = imm;
    id_ex_next.ctrl  = ctrl;
  end

  // ID/EX register, a cleared word is the bubble
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      id_ex <= '0;
    end else if (!ex_hold) begin
      id_ex <= issue ? id_ex_next : '0;
    end
  end

  // Execute must never see side effects from a bubble
  a_bubble_quiet : assert property (@(posedge bus) disable iff (!rst_n)
    !id_ex.valid |-> (id_ex.ctrl == '0));

  a_hold_stable : assert property (@(posedge bus) disable iff (!rst_n)
    ex_hold |=> $stable(id_ex));

endmodule

`default_nettype wire

/* rtl/decode_top.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_top (
  input  logic               bus,
  input  logic               rst_n,
  input  logic               fetch_req,
  input  decode_pkg::fetch_t fetch_data,
  output logic               fetch_ack,
  input  logic               ex_hold,
  output decode_pkg::id_ex_t id_ex
);

  decode_pkg::fetch_t head;
  logic               head_valid;
  logic               pop;

  // Four-phase receiver and queue
  fetch_buffer #(
    .payload_t (decode_pkg::fetch_t),
    .depth     (decode_pkg::fetch_depth)
  ) fetch_buffer_i (
    .bus        (bus),
    .rst_n      (rst_n),
    .fetch_req  (fetch_req),
    .fetch_data (fetch_data),
    .fetch_ack  (fetch_ack),
    .head       (head),
    .head_valid (head_valid),
    .pop        (pop)
  );

  decode_stage decode_stage_i (
    .bus        (bus),
    .rst_n      (rst_n),
    .ex_hold    (ex_hold),
    .head       (head),
    .head_valid (head_valid),
    .pop        (pop),
    .id_ex      (id_ex)
  );

endmodule

`default_nettype wire

/* rtl/fetch_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_buffer #(
  parameter type payload_t = decode_pkg::fetch_t,
  parameter int  depth     = decode_pkg::fetch_depth
) (
  input  logic     bus,
  input  logic     rst_n,
  input  logic     fetch_req,
  input  payload_t fetch_data,
  output logic     fetch_ack,
  output payload_t head,
  output logic     head_valid,
  input  logic     pop
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  payload_t           mem [depth];
  logic [ptr_w-1:0]   wr_ptr;
  logic [ptr_w-1:0]   rd_ptr;
  logic [cnt_w-1:0]   count;
  logic               full;
  logic               wr_en;

  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
    return (p == ptr_w'(depth - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full       = (count == cnt_w'(depth));
  assign head_valid = (count != '0);
  assign head       = mem[rd_ptr];

  // New request, previous cycle fully closed, room left
  assign wr_en = fetch_req && !fetch_ack && !full;

  ////////////////////////////////////////
  // Handshake and pointers
  ////////////////////////////////////////

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      fetch_ack <= 1'b0;
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
    end else begin
      if (wr_en) begin
        fetch_ack <= 1'b1;
        wr_ptr    <= ptr_inc(wr_ptr);
      end else if (fetch_ack && !fetch_req) begin
        fetch_ack <= 1'b0;
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({wr_en, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage
  always_ff @(posedge bus) begin
    if (wr_en) begin
      mem[wr_ptr] <= fetch_data;
    end
  end

  // Decode takes only an entry that is shown to it
  a_pop_valid : assert property (@(posedge bus) disable iff (!rst_n)
    pop |-> head_valid);

  // Count never passes depth and a full queue has both pointers on the head
  a_no_overflow : assert property (@(posedge bus) disable iff (!rst_n)
    (count <= cnt_w'(depth)) && (!full || (wr_ptr == rd_ptr)));

endmodule

`default_nettype wire

/* rtl/hazard_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
  input  logic [4:0] rs1,
  input  logic [4:0] rs2,
  input  logic       uses_rs1,
  input  logic       uses_rs2,
  input  logic [4:0] id_ex_rd,
  input  logic       id_ex_memread,
  output logic       stall
);

  logic rd_live;
  logic hit_rs1;
  logic hit_rs2;

  // x0 never carries a pending load result
  assign rd_live = id_ex_memread && (id_ex_rd != 5'd0);

  assign hit_rs1 = uses_rs1 && (rs1 == id_ex_rd);
  assign hit_rs2 = uses_rs2 && (rs2 == id_ex_rd);

  // Load data arrives one stage too late for a dependent op
  assign stall = rd_live && (hit_rs1 || hit_rs2);

endmodule

`default_nettype wire

/* rtl/imm_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
  input  logic [decode_pkg::xlen-1:0] ins,
  output logic [decode_pkg::xlen-1:0] imm
);

  logic [6:0] opcode;

  assign opcode = ins[6:0];

  always_comb begin
    unique case (opcode)
      // I format
      decode_pkg::op_imm, decode_pkg::op_load, decode_pkg::op_jalr:
        imm = {{20{ins[31]}}, ins[31:20]};
      // S format
      decode_pkg::op_store:
        imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      // B format, offset in halfwords
      decode_pkg::op_branch:
        imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      // U format
      decode_pkg::op_lui, decode_pkg::op_auipc:
        imm = {ins[31:12], 12'b0};
      // J format
      decode_pkg::op_jal:
        imm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      default:
        imm = '0;
    endcase
  end

endmodule

`default_nettype wire

/* test/decode_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_tb;

  localparam int limit = 400;

  logic               bus;
  logic               rst_n;
  logic               fetch_req;
  decode_pkg::fetch_t fetch_data;
  logic               fetch_ack;
  logic               ex_hold;
  decode_pkg::id_ex_t id_ex;

  // Expected decode per accepted entry, with its bubble count or -1
  decode_pkg::id_ex_t exp_q[$];
  int                 gap_q[$];
  int unsigned        seed = 98413;
  int                 errors = 0;
  int                 checks = 0;
  int                 mark = 0;
  int                 accepted = 0;
  int                 cycle = 0;
  int                 last_issue = 0;

  decode_top decode_top_i (
    .bus        (bus),
    .rst_n      (rst_n),
    .fetch_req  (fetch_req),
    .fetch_data (fetch_data),
    .fetch_ack  (fetch_ack),
    .ex_hold    (ex_hold),
    .id_ex      (id_ex)
  );

  initial begin
    bus = 1'b0;
    forever #20 bus = ~bus;
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  function automatic void note_failure(input string what);
    $display("%s", what);
    errors++;
  endfunction

  ////////////////////////////////////////
  // Reference decoder
  ////////////////////////////////////////

  function automatic decode_pkg::alu_op_e arith_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? decode_pkg::alu_sub : decode_pkg::alu_add;
      3'b001:  return decode_pkg::alu_sll;
      3'b010:  return decode_pkg::alu_slt;
      3'b011:  return decode_pkg::alu_sltu;
      3'b100:  return decode_pkg::alu_xor;
      3'b101:  return alt ? decode_pkg::alu_sra : decode_pkg::alu_srl;
      3'b110:  return decode_pkg::alu_or;
      default: return decode_pkg::alu_and;
    endcase
  endfunction

  function automatic decode_pkg::id_ex_t ref_decode(input decode_pkg::fetch_t f);
    decode_pkg::id_ex_t e;
    logic [31:0]        i;
    logic [31:0]        imm_i;
    i     = f.ins;
    imm_i = {{21{i[31]}}, i[30:20]};
    e     = '0;
    e.valid = 1'b1;
    e.pc    = f.pc;
    e.rs1   = i[19:15];
    e.rs2   = i[24:20];
    e.rd    = i[11:7];
    e.ctrl.mem_size = i[14:12];
    case (i[6:0])
      decode_pkg::op_lui, decode_pkg::op_auipc: begin
        e.imm = {i[31:12], 12'h000};
        e.ctrl.alusrc   = 1'b1;
        e.ctrl.regwrite = 1'b1;
        e.ctrl.lui      = (i[6:0] == decode_pkg::op_lui);
        e.ctrl.auipc    = (i[6:0] == decode_pkg::op_auipc);
        e.ctrl.alu_op   = e.ctrl.lui ? decode_pkg::alu_pass_b : decode_pkg::alu_add;
        e.ctrl.mem_size = 3'b000;
      end
      decode_pkg::op_jal: begin
        e.imm = {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
        e.ctrl.regwrite = 1'b1;
        e.ctrl.jal      = 1'b1;
        e.ctrl.mem_size = 3'b000;
      end
      decode_pkg::op_jalr: begin
        e.imm = imm_i;
        e.ctrl.alusrc   = 1'b1;
        e.ctrl.regwrite = 1'b1;
        e.ctrl.jalr     = 1'b1;
      end
      decode_pkg::op_branch: begin
        e.imm = {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
        e.ctrl.branch = 1'b1;
        // beq/bne compare by subtract, the rest by set-less-than
        if (i[14] && !i[13]) e.ctrl.alu_op = decode_pkg::alu_slt;
        else if (i[14]) e.ctrl.alu_op = decode_pkg::alu_sltu;
        else e.ctrl.alu_op = decode_pkg::alu_sub;
      end
      decode_pkg::op_load: begin
        e.imm = imm_i;
        e.ctrl.alusrc   = 1'b1;
        e.ctrl.memread  = 1'b1;
        e.ctrl.regwrite = 1'b1;
      end
      decode_pkg::op_store: begin
        e.imm = {{21{i[31]}}, i[30:25], i[11:7]};
        e.ctrl.alusrc   = 1'b1;
        e.ctrl.memwrite = 1'b1;
      end
      decode_pkg::op_imm: begin
        e.imm = imm_i;
        e.ctrl.alusrc   = 1'b1;
        e.ctrl.regwrite = 1'b1;
        e.ctrl.alu_op   = arith_op(i[14:12], (i[14:12] == 3'b101) && i[30]);
      end
      decode_pkg::op_reg: begin
        e.ctrl.regwrite = 1'b1;
        e.ctrl.alu_op   = arith_op(i[14:12], i[30]);
      end
      default: begin
        e.ctrl.illegal  = 1'b1;
        e.ctrl.mem_size = 3'b000;
      end
    endcase
    return e;
  endfunction

  // One bubble when a load's nonzero rd feeds a used source of the next op
  function automatic int expect_gap(input logic [31:0] prev, input logic [31:0] cur);
    logic [6:0] op;
    bit         use1;
    bit         use2;
    op   = cur[6:0];
    use1 = op inside {decode_pkg::op_jalr, decode_pkg::op_branch, decode_pkg::op_load,
                      decode_pkg::op_store, decode_pkg::op_imm, decode_pkg::op_reg};
    use2 = op inside {decode_pkg::op_branch, decode_pkg::op_store, decode_pkg::op_reg};
    if (prev[6:0] != decode_pkg::op_load || prev[11:7] == 5'd0) return 0;
    return ((use1 && cur[19:15] == prev[11:7]) || (use2 && cur[24:20] == prev[11:7])) ? 1 : 0;
  endfunction

  // Legal encodings per kind, kind 9 is an unsupported opcode
  function automatic logic [31:0] random_ins(input int kind);
    logic [31:0] r;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [6:0]  op;
    r  = next_rand();
    f3 = r[14:12];
    f7 = {1'b0, r[30], 5'b00000};
    case (kind)
      0: return {r[31:7], decode_pkg::op_lui};
      1: return {r[31:7], decode_pkg::op_auipc};
      2: return {r[31:7], decode_pkg::op_jal};
      3: return {r[31:15], 3'b000, r[11:7], decode_pkg::op_jalr};
      4: begin
        if (f3[2:1] == 2'b01) f3[1] = 1'b0;
        return {r[31:15], f3, r[11:7], decode_pkg::op_branch};
      end
      5: begin
        if (f3 == 3'b011 || f3[2:1] == 2'b11) f3 = 3'b010;
        return {r[31:15], f3, r[11:7], decode_pkg::op_load};
      end
      6: return {r[31:15], f3 % 3'd3, r[11:7], decode_pkg::op_store};
      7: begin
        if (f3 == 3'b001 || f3 == 3'b101) return {f7, r[24:15], f3, r[11:7], decode_pkg::op_imm};
        return {r[31:15], f3, r[11:7], decode_pkg::op_imm};
      end
      8: begin
        if (f3 != 3'b000 && f3 != 3'b101) f7 = 7'd0;
        return {f7, r[24:15], f3, r[11:7], decode_pkg::op_reg};
      end
      default: begin
        case (r[1:0])
          2'd0:    op = 7'b0001111;
          2'd1:    op = 7'b1110011;
          2'd2:    op = 7'b0000000;
          default: op = 7'b1111111;
        endcase
        return {r[31:7], op};
      end
    endcase
  endfunction

  ////////////////////////////////////////
  // Drivers and waits
  ////////////////////////////////////////

  task automatic stop_on_timeout(input bit expired, input string what);
    if (expired) begin
      $display("Timeout: %s", what);
      $display("RESULT: FAIL");
      $finish;
    end
  endtask

  // One four-phase cycle, req kept high for linger cycles after ack
  task automatic fetch_word(input logic [31:0] ins, input int gap, input int linger);
    decode_pkg::fetch_t f;
    int                 n;
    f.pc  = 16'(accepted * 4);
    f.ins = ins;
    @(posedge bus);
    fetch_data <= f;
    fetch_req  <= 1'b1;
    n = 0;
    while (!fetch_ack && n < limit) begin
      @(posedge bus);
      n++;
    end
    stop_on_timeout(!fetch_ack, "fetch_ack never rose");
    exp_q.push_back(ref_decode(f));
    gap_q.push_back(gap);
    accepted++;
    repeat (linger) @(posedge bus);
    fetch_req <= 1'b0;
    n = 0;
    while (fetch_ack && n < limit) begin
      @(posedge bus);
      n++;
    end
    stop_on_timeout(fetch_ack, "fetch_ack never fell");
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < limit) begin
      @(posedge bus);
      n++;
    end
    stop_on_timeout(exp_q.size() != 0, "expected entries never left decode");
    repeat (2) @(posedge bus);
  endtask

  // Both entries sit in the queue before release so only hazards make gaps
  task automatic run_pair(input logic [31:0] first, input logic [31:0] second);
    @(posedge bus);
    ex_hold <= 1'b1;
    fetch_word(first, -1, 0);
    fetch_word(second, expect_gap(first, second), 0);
    ex_hold <= 1'b0;
    drain();
  endtask

  task automatic end_test(input int num, input string name);
    $display("test %0d %s: %0d errors", num, name, errors - mark);
    mark = errors;
  endtask

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    checks++;
    assert (got === want)
    else begin
      $display("ERROR %s got 0x%h expected 0x%h", name, got, want);
      errors++;
    end
  endtask

  task automatic compare_output();
    decode_pkg::id_ex_t e;
    int                 gap;
    assert (exp_q.size() != 0) begin
      e   = exp_q.pop_front();
      gap = gap_q.pop_front();
      check_field("id_ex.pc", id_ex.pc, e.pc);
      check_field("id_ex.rs1", id_ex.rs1, e.rs1);
      check_field("id_ex.rs2", id_ex.rs2, e.rs2);
      check_field("id_ex.rd", id_ex.rd, e.rd);
      check_field("id_ex.imm", id_ex.imm, e.imm);
      check_field("id_ex.ctrl.alu_op", id_ex.ctrl.alu_op, e.ctrl.alu_op);
      check_field("id_ex.ctrl flags", id_ex.ctrl[12:0], e.ctrl[12:0]);
      if (gap >= 0) check_field("bubble cycles", cycle - last_issue - 1, gap);
    end else note_failure("decode issued an entry that was never fetched");
    last_issue = cycle;
  endtask

  // Execute takes id_ex on any edge where it is valid and not held
  always @(posedge bus) begin
    if (rst_n) begin
      cycle++;
      if (id_ex.valid && !ex_hold) compare_output();
    end
  end

  a_ack_needs_req : assert property (@(posedge bus) disable iff (!rst_n)
    $rose(fetch_ack) |-> $past(fetch_req))
    else note_failure("fetch_ack rose while fetch_req was low");

  a_ack_holds : assert property (@(posedge bus) disable iff (!rst_n)
    (fetch_ack && fetch_req) |=> fetch_ack)
    else note_failure("fetch_ack dropped while fetch_req was still high");

  a_ack_falls : assert property (@(posedge bus) disable iff (!rst_n)
    (fetch_ack && !fetch_req) |=> !fetch_ack)
    else note_failure("fetch_ack stayed high after fetch_req fell");

  a_hold_freezes : assert property (@(posedge bus) disable iff (!rst_n)
    ex_hold |=> $stable(id_ex))
    else note_failure("id_ex changed while ex_hold was high");

  a_bubble_clean : assert property (@(posedge bus) disable iff (!rst_n)
    !id_ex.valid |-> (id_ex.ctrl == '0))
    else note_failure("a bubble carried nonzero control bits");

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    int i;
    int n;
    int base;
    rst_n      = 1'b0;
    fetch_req  = 1'b0;
    fetch_data = '0;
    ex_hold    = 1'b0;
    repeat (16) @(posedge bus);
    check_field("fetch_ack", fetch_ack, 0);
    check_field("id_ex.valid", id_ex.valid, 0);
    check_field("id_ex.ctrl", id_ex.ctrl, 0);
    rst_n <= 1'b1;
    end_test(1, "reset state");

    // Every opcode kind four times over
    for (i = 0; i < 40; i++) fetch_word(random_ins(i % 10), -1, 0);
    drain();
    end_test(2, "random decode");

    run_pair({12'h010, 5'd2, 3'b010, 5'd5, decode_pkg::op_load},
             {7'd0, 5'd2, 5'd5, 3'b000, 5'd7, decode_pkg::op_reg});
    run_pair({12'h020, 5'd3, 3'b010, 5'd0, decode_pkg::op_load},
             {7'd0, 5'd0, 5'd0, 3'b000, 5'd7, decode_pkg::op_reg});
    run_pair({12'h030, 5'd3, 3'b010, 5'd5, decode_pkg::op_load},
             {7'd0, 5'd2, 5'd6, 3'b000, 5'd7, decode_pkg::op_reg});
    run_pair({12'h040, 5'd3, 3'b010, 5'd5, decode_pkg::op_load},
             {7'd0, 5'd5, 5'd1, 3'b010, 5'd4, decode_pkg::op_store});
    end_test(3, "load-use bubble");

    fork
      for (i = 0; i < 10; i++) fetch_word(random_ins(int'(next_rand() % 10)), -1, 0);
      begin
        repeat (8) @(posedge bus);
        ex_hold <= 1'b1;
        repeat (12) @(posedge bus);
        ex_hold <= 1'b0;
      end
    join
    drain();
    end_test(4, "hold mid-stream");

    @(posedge bus);
    ex_hold <= 1'b1;
    base = accepted;
    fork
      for (i = 0; i < 6; i++) fetch_word(random_ins(i % 10), -1, 0);
      begin
        n = 0;
        while (accepted < base + 4 && n < limit) begin
          @(posedge bus);
          n++;
        end
        stop_on_timeout(accepted < base + 4, "buffer never took four entries");
        repeat (10) @(posedge bus);
        assert (accepted == base + 4 && !fetch_ack && fetch_req)
        else note_failure("fetch buffer acknowledged a fifth entry while full");
        ex_hold <= 1'b0;
      end
    join
    drain();
    end_test(5, "full buffer");

    // Slow producer keeps req high after ack
    for (i = 0; i < 4; i++) fetch_word(random_ins(i % 10), -1, 3);
    drain();
    end_test(6, "four-phase handshake");

    $display("tests 6, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
